/* Makefile */
# Verilator build and run of the energy monitor testbench

VERILATOR ?= verilator
TOP       ?= tb_energy_monitor
FILELIST  ?= energy_monitor.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* energy_monitor.f */
+incdir+logic
logic/energy_monitor_pkg.sv
logic/input_pipe.sv
logic/step_counter.sv
logic/monitor_ctrl.sv
logic/partial_energy_calc.sv
logic/energy_accumulator.sv
logic/energy_monitor.sv
test/tb_clock_gen.sv
test/tb_energy_monitor.sv

/* logic/energy_accumulator.sv */
// Frame accumulator, sums row energies, halves the total and holds the result until accepted
`timescale 1ns/1ps

module energy_accumulator
    import energy_monitor_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     valid_i,
    input  logic     last_i,
    input  row_sum_t sum_i,
    input  logic     clear_i,
    output logic     done_o,
    output energy_t  energy_o
);

    energy_dbl_t total_q;
    energy_dbl_t total_d;
    energy_dbl_t half_total;
    energy_t     energy_q;
    logic        done_q;

    // Every pair is counted twice, signed divide truncates toward zero
    assign total_d    = total_q + energy_dbl_t'(sum_i);
    assign half_total = total_d / 2;

    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            total_q <= '0;
            done_q  <= 1'b0;
        end else if (valid_i) begin
            total_q <= total_d;
            // Last rows of the frame close it
            if (last_i) begin
                done_q <= 1'b1;
            end
        end
    end

    // Held result, stable while done is high
    always_ff @(posedge clk_i) begin
        if (valid_i && last_i) begin
            energy_q <= energy_t'(half_total);
        end
    end

    assign done_o   = done_q;
    assign energy_o = energy_q;

endmodule

/* logic/energy_monitor.sv */
// Top level of the Ising-machine energy monitor, one signed energy per frame of config, spins and weights
`timescale 1ns/1ps
`include "energy_monitor_macros.svh"

module energy_monitor
    import energy_monitor_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_i,
    // Config interface
    input  logic         config_valid_i,
    input  spin_idx_t    config_counter_i,
    output logic         config_ready_o,
    // Spin interface
    input  logic         spin_valid_i,
    input  spin_vec_t    spin_i,
    output logic         spin_ready_o,
    // Weight interface
    input  logic         weight_valid_i,
    input  weight_beat_t weight_i,
    output logic         weight_ready_o,
    // Energy interface
    output logic         energy_valid_o,
    output energy_t      energy_o,
    input  logic         energy_ready_i,
    // Cached spins of the current frame
    output spin_vec_t    spin_o
);

    // Pipe outputs toward the controller
    logic         cfg_valid, cfg_ready;
    spin_idx_t    cfg_index;
    logic         spn_valid, spn_ready;
    spin_vec_t    spn_data;
    logic         wgt_valid, wgt_ready;
    weight_beat_t wgt_beat;

    logic      wgt_hs;
    logic      energy_hs;
    spin_idx_t spin_index;
    logic      wgt_last;
    spin_vec_t spin_cache_q;
    logic [`EM_PARALLELISM-1:0] row_spin;

    // Registered row results
    local_energy_t row_local [`EM_PARALLELISM];
    logic [`EM_PARALLELISM-1:0] row_valid;
    logic [`EM_PARALLELISM-1:0] row_last;
    row_sum_t row_sum;
    logic     acc_done;

    input_pipe #(.data_t(spin_idx_t)) u_config_pipe (
        .clk_i(clk_i), .reset_i(reset_i),
        .valid_i(config_valid_i), .data_i(config_counter_i), .ready_o(config_ready_o),
        .valid_o(cfg_valid), .data_o(cfg_index), .ready_i(cfg_ready)
    );
    input_pipe #(.data_t(spin_vec_t)) u_spin_pipe (
        .clk_i(clk_i), .reset_i(reset_i),
        .valid_i(spin_valid_i), .data_i(spin_i), .ready_o(spin_ready_o),
        .valid_o(spn_valid), .data_o(spn_data), .ready_i(spn_ready)
    );
    input_pipe #(.data_t(weight_beat_t)) u_weight_pipe (
        .clk_i(clk_i), .reset_i(reset_i),
        .valid_i(weight_valid_i), .data_i(weight_i), .ready_o(weight_ready_o),
        .valid_o(wgt_valid), .data_o(wgt_beat), .ready_i(wgt_ready)
    );

    assign wgt_hs    = wgt_valid & wgt_ready;
    assign energy_hs = energy_valid_o & energy_ready_i;

    monitor_ctrl u_ctrl (
        .clk_i(clk_i), .reset_i(reset_i),
        .config_valid_i(cfg_valid), .config_ready_o(cfg_ready),
        .spin_valid_i(spn_valid), .spin_ready_o(spn_ready),
        .weight_valid_i(wgt_valid), .weight_ready_o(wgt_ready),
        .last_i(wgt_last), .done_i(acc_done),
        .energy_valid_o(energy_valid_o), .energy_ready_i(energy_ready_i)
    );

    // Row index of the beat waiting in the weight pipe
    step_counter u_counter (
        .clk_i(clk_i), .reset_i(reset_i),
        .load_i(cfg_valid & cfg_ready), .start_i(cfg_index),
        .step_i(wgt_hs), .index_o(spin_index), .last_o(wgt_last)
    );

    // Spin cache, written once per frame
    always_ff @(posedge clk_i) begin
        if (spn_valid && spn_ready) begin
            spin_cache_q <= spn_data;
        end
    end
    assign spin_o = spin_cache_q;

    // Little-endian row spins, row r is spin counter+r
    always_comb begin
        for (int r = 0; r < `EM_PARALLELISM; r++) begin
            row_spin[r] = spin_cache_q[(int'(spin_index) + r) % `EM_NUM_SPIN];
        end
    end

    for (genvar r = 0; r < `EM_PARALLELISM; r++) begin : g_row
        // Only row 0 carries the frame end
        partial_energy_calc u_row (
            .clk_i(clk_i), .reset_i(reset_i),
            .valid_i(wgt_hs), .last_i((r == 0) ? wgt_last : 1'b0),
            .spins_i(spin_cache_q), .row_spin_i(row_spin[r]), .coef_i(wgt_beat[r]),
            .local_o(row_local[r]), .valid_o(row_valid[r]), .last_o(row_last[r])
        );
    end

    // Adder tree over the registered row energies
    always_comb begin
        row_sum = '0;
        for (int r = 0; r < `EM_PARALLELISM; r++) begin
            row_sum = row_sum + row_sum_t'(row_local[r]);
        end
    end

    // Rows move in lockstep, valids are identical
    energy_accumulator u_accum (
        .clk_i(clk_i), .reset_i(reset_i),
        .valid_i(&row_valid), .last_i(|row_last), .sum_i(row_sum),
        .clear_i(energy_hs), .done_o(acc_done), .energy_o(energy_o)
    );

endmodule

/* logic/energy_monitor_macros.svh */
// Problem size and bit widths of the energy monitor, included by the package, the RTL and the testbench
`ifndef ENERGY_MONITOR_MACROS_SVH
`define ENERGY_MONITOR_MACROS_SVH

// Number of spins in one frame
`define EM_NUM_SPIN 16

// Matrix rows carried by one weight beat, NUM_SPIN must be a multiple of it
`define EM_PARALLELISM 2

// Signed width of one J element
`define EM_BITJ 4

// Signed width of the bias h
`define EM_BITH 4

// Unsigned width of the bias scale k
`define EM_SCALING_BIT 4

// Width of the energy returned to the host
`define EM_ENERGY_BIT 32

// Width of a spin index
`define EM_SPINIDX_BIT $clog2(`EM_NUM_SPIN)

// Local energy width, covers the J sum plus h*k with sign
`define EM_LOCAL_BIT (`EM_SPINIDX_BIT + `EM_BITJ + `EM_BITH + `EM_SCALING_BIT)

`endif

/* logic/energy_monitor_pkg.sv */
// Shared types of the energy monitor, imported by every RTL module that handles spins or energies
`include "energy_monitor_macros.svh"

package energy_monitor_pkg;

    // Spin vector, bit 1 is +1 and bit 0 is -1
    typedef logic [`EM_NUM_SPIN-1:0] spin_vec_t;

    // Spin index, also the row counter
    typedef logic [`EM_SPINIDX_BIT-1:0] spin_idx_t;

    // One coupling element and one full matrix row
    typedef logic signed [`EM_BITJ-1:0] j_elem_t;
    typedef j_elem_t [`EM_NUM_SPIN-1:0] j_row_t;

    // Bias and its unsigned scale
    typedef logic signed [`EM_BITH-1:0] h_bias_t;
    typedef logic [`EM_SCALING_BIT-1:0] h_scale_t;

    // Everything one row unit needs
    typedef struct packed {
        j_row_t j;
        h_bias_t h;
        h_scale_t k;
    } row_coef_t;

    // Element r holds row counter+r
    typedef row_coef_t [`EM_PARALLELISM-1:0] weight_beat_t;

    // Energy types
    typedef logic signed [`EM_LOCAL_BIT-1:0] local_energy_t;
    typedef logic signed [`EM_LOCAL_BIT+$clog2(`EM_PARALLELISM):0] row_sum_t;
    typedef logic signed [`EM_ENERGY_BIT-1:0] energy_t;
    // Doubled total before halving, one extra bit
    typedef logic signed [`EM_ENERGY_BIT:0] energy_dbl_t;

    // Frame controller phases
    typedef enum logic [2:0] {
        CFG,
        SPIN,
        WEIGHT,
        DRAIN,
        OUTPUT
    } ctrl_state_e;

endpackage

/* logic/input_pipe.sv */
// Single valid/ready register slice placed on each input interface of the energy monitor
`timescale 1ns/1ps

module input_pipe #(
    parameter type data_t = logic
) (
    input  logic  clk_i,
    input  logic  reset_i,
    // Upstream side
    input  logic  valid_i,
    input  data_t data_i,
    output logic  ready_o,
    // Downstream side
    output logic  valid_o,
    output data_t data_o,
    input  logic  ready_i
);

    logic  valid_q;
    data_t data_q;

    // Stage can take a beat when empty or when it drains this cycle
    assign ready_o = ~valid_q | ready_i;

    // Occupancy flag
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    // Payload, only loaded on an accepted beat
    always_ff @(posedge clk_i) begin
        if (ready_o && valid_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

/* logic/monitor_ctrl.sv */
// Frame controller of the energy monitor, opens one input phase at a time and owns the energy valid
`timescale 1ns/1ps

module monitor_ctrl
    import energy_monitor_pkg::*;
(
    input  logic clk_i,
    input  logic reset_i,
    // Config phase
    input  logic config_valid_i,
    output logic config_ready_o,
    // Spin phase
    input  logic spin_valid_i,
    output logic spin_ready_o,
    // Weight phase
    input  logic weight_valid_i,
    output logic weight_ready_o,
    // Counter says this beat ends the matrix
    input  logic last_i,
    // Accumulator holds the finished energy
    input  logic done_i,
    // Result handshake
    output logic energy_valid_o,
    input  logic energy_ready_i
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // Phase sequencing
    always_comb begin
        state_d = state_q;
        case (state_q)
            CFG: begin
                // Start index loads on this beat
                if (config_valid_i) begin
                    state_d = SPIN;
                end
            end
            SPIN: begin
                if (spin_valid_i) begin
                    state_d = WEIGHT;
                end
            end
            WEIGHT: begin
                // Stay here until the beat that wraps the counter
                if (weight_valid_i && last_i) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                // Row units and accumulator still busy
                if (done_i) begin
                    state_d = OUTPUT;
                end
            end
            OUTPUT: begin
                if (energy_ready_i) begin
                    state_d = CFG;
                end
            end
            default: begin
                state_d = CFG;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= CFG;
        end else begin
            state_q <= state_d;
        end
    end

    // One ready per phase, never two at once
    assign config_ready_o = (state_q == CFG);
    assign spin_ready_o   = (state_q == SPIN);
    assign weight_ready_o = (state_q == WEIGHT);
    // Held until the host takes the energy
    assign energy_valid_o = (state_q == OUTPUT);

endmodule

/* logic/partial_energy_calc.sv */
// Local energy of one matrix row, registered, one instance per row of a weight beat
`timescale 1ns/1ps
`include "energy_monitor_macros.svh"

module partial_energy_calc
    import energy_monitor_pkg::*;
(
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          valid_i,
    input  logic          last_i,
    // Whole cached spin vector
    input  spin_vec_t     spins_i,
    // Spin of this row
    input  logic          row_spin_i,
    input  row_coef_t     coef_i,
    output local_energy_t local_o,
    output logic          valid_o,
    output logic          last_o
);

    local_energy_t field_sum;
    local_energy_t bias_term;
    local_energy_t local_d;
    local_energy_t local_q;
    logic          valid_q;
    logic          last_q;

    // Sum of J_ij * sigma_j plus h*k
    always_comb begin
        local_energy_t j_val;
        field_sum = '0;
        for (int j = 0; j < `EM_NUM_SPIN; j++) begin
            j_val = local_energy_t'($signed(coef_i.j[j]));
            // Spin 0 flips the sign of the coupling
            if (spins_i[j]) begin
                field_sum = field_sum + j_val;
            end else begin
                field_sum = field_sum - j_val;
            end
        end
        // k is unsigned, zero extended before the signed product
        bias_term = local_energy_t'($signed(coef_i.h)) *
                    local_energy_t'($signed({1'b0, coef_i.k}));
        // Row spin of -1 negates the whole row
        if (row_spin_i) begin
            local_d = field_sum + bias_term;
        end else begin
            local_d = -(field_sum + bias_term);
        end
    end

    // Result register, payload only
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            local_q <= local_d;
        end
    end

    // Flags travel with the result
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= valid_i;
            last_q  <= valid_i & last_i;
        end
    end

    assign local_o = local_q;
    assign valid_o = valid_q;
    assign last_o  = last_q;

endmodule

/* logic/step_counter.sv */
// Spin-index counter for the weight phase, loaded from the config beat and stepped per weight beat
`timescale 1ns/1ps
`include "energy_monitor_macros.svh"

module step_counter
    import energy_monitor_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      load_i,
    input  spin_idx_t start_i,
    input  logic      step_i,
    output spin_idx_t index_o,
    output logic      last_o
);

    spin_idx_t index_q;
    spin_idx_t next_index;
    int        next_sum;

    // Next index, wrapped back into 0..NUM_SPIN-1
    always_comb begin
        next_sum = int'(index_q) + `EM_PARALLELISM;
        // This beat covers the top rows of the matrix
        last_o = (next_sum >= `EM_NUM_SPIN);
        if (last_o) begin
            next_index = spin_idx_t'(next_sum - `EM_NUM_SPIN);
        end else begin
            next_index = spin_idx_t'(next_sum);
        end
    end

    // Load has priority, a frame never loads and steps together
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            index_q <= '0;
        end else if (load_i) begin
            index_q <= start_i;
        end else if (step_i) begin
            index_q <= next_index;
        end
    end

    assign index_o = index_q;

endmodule

/* test/tb_clock_gen.sv */
// Free-running clock for the energy monitor testbench, instantiated once by its top module
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    // Low at time zero, first rising edge half a period later
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        clk_o = ~clk_o;
    end

endmodule

/* test/tb_energy_monitor.sv */
// Directed testbench of the energy monitor and top module of the simulation built from the file list
`timescale 1ns/1ps
`include "energy_monitor_macros.svh"

module tb_energy_monitor
    import energy_monitor_pkg::*;
();

    localparam int NUM     = `EM_NUM_SPIN;
    localparam int PAR     = `EM_PARALLELISM;
    // Longest single wait in cycles
    localparam int TIMEOUT = 200;

    logic         clk;
    logic         reset_i;
    logic         config_valid_i;
    spin_idx_t    config_counter_i;
    logic         config_ready_o;
    logic         spin_valid_i;
    spin_vec_t    spin_i;
    logic         spin_ready_o;
    logic         weight_valid_i;
    weight_beat_t weight_i;
    logic         weight_ready_o;
    logic         energy_valid_o;
    energy_t      energy_o;
    logic         energy_ready_i;
    spin_vec_t    spin_o;

    int checks   = 0;
    int errors   = 0;
    int timeouts = 0;

    // Galois LFSR over x^16+x^14+x^13+x^11+1
    logic [15:0] lfsr_state = 16'd25;

    // Current frame as plain integers for the reference model
    spin_vec_t frame_spins;
    int        j_mat [NUM][NUM];
    int        h_vec [NUM];
    int        k_vec [NUM];

    tb_clock_gen #(.PERIOD_NS(20)) u_clock (.clk_o(clk));

    energy_monitor energy_monitor_inst (
        .clk_i(clk), .reset_i(reset_i),
        .config_valid_i(config_valid_i), .config_counter_i(config_counter_i),
        .config_ready_o(config_ready_o),
        .spin_valid_i(spin_valid_i), .spin_i(spin_i), .spin_ready_o(spin_ready_o),
        .weight_valid_i(weight_valid_i), .weight_i(weight_i), .weight_ready_o(weight_ready_o),
        .energy_valid_o(energy_valid_o), .energy_o(energy_o), .energy_ready_i(energy_ready_i),
        .spin_o(spin_o)
    );

    // One LFSR step per bit
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out_bit;
    endfunction

    function automatic int unsigned random_bits(int count);
        int unsigned value;
        value = 0;
        for (int b = 0; b < count; b++) begin
            value = (value << 1) | 32'(next_random_bit());
        end
        return value;
    endfunction

    // Two's complement value of the given width
    function automatic int random_signed(int width);
        int value;
        value = int'(random_bits(width));
        if (value >= (1 << (width - 1))) begin
            value = value - (1 << width);
        end
        return value;
    endfunction

    function automatic void fill_uniform(logic spin_bit, int j_val, int h_val, int k_val);
        frame_spins = {NUM{spin_bit}};
        for (int i = 0; i < NUM; i++) begin
            for (int j = 0; j < NUM; j++) begin
                j_mat[i][j] = j_val;
            end
            h_vec[i] = h_val;
            k_vec[i] = k_val;
        end
    endfunction

    function automatic void fill_random();
        frame_spins = spin_vec_t'(random_bits(NUM));
        for (int i = 0; i < NUM; i++) begin
            for (int j = 0; j < NUM; j++) begin
                j_mat[i][j] = random_signed(`EM_BITJ);
            end
            h_vec[i] = random_signed(`EM_BITH);
            k_vec[i] = int'(random_bits(`EM_SCALING_BIT));
        end
    endfunction

    // Sum of sigma_i*(sum_j J_ij*sigma_j + h_i*k_i) halved toward zero
    function automatic int model_energy();
        int total;
        int field;
        int si;
        total = 0;
        for (int i = 0; i < NUM; i++) begin
            si = frame_spins[i] ? 1 : -1;
            field = h_vec[i] * k_vec[i];
            for (int j = 0; j < NUM; j++) begin
                field = field + j_mat[i][j] * (frame_spins[j] ? 1 : -1);
            end
            total = total + si * field;
        end
        return total / 2;
    endfunction

    // Row base+r goes to element r
    function automatic weight_beat_t build_beat(int base);
        weight_beat_t beat;
        for (int r = 0; r < PAR; r++) begin
            for (int j = 0; j < NUM; j++) begin
                beat[r].j[j] = j_elem_t'(j_mat[base + r][j]);
            end
            beat[r].h = h_bias_t'(h_vec[base + r]);
            beat[r].k = h_scale_t'(k_vec[base + r]);
        end
        return beat;
    endfunction

    task automatic check_energy(energy_t got, energy_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, energy %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_spins(spin_vec_t got, spin_vec_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, spins %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, flag %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic note_timeout(string what);
        timeouts++;
        $display("Timed out after %0d cycles: %s", TIMEOUT, what);
    endtask

    task automatic apply_reset();
        reset_i = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
    endtask

    // Handshake tasks start and end on a falling edge
    // Ready seen high on a falling edge means the transfer happens on the next rising edge
    task automatic send_config(spin_idx_t start);
        int waited;
        waited = 0;
        config_valid_i = 1'b1;
        config_counter_i = start;
        while (!config_ready_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!config_ready_o) begin
            note_timeout("config_ready_o never rose");
        end
        @(negedge clk);
        config_valid_i = 1'b0;
    endtask

    task automatic send_spins(spin_vec_t spins);
        int waited;
        waited = 0;
        spin_valid_i = 1'b1;
        spin_i = spins;
        while (!spin_ready_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!spin_ready_o) begin
            note_timeout("spin_ready_o never rose");
        end
        @(negedge clk);
        spin_valid_i = 1'b0;
    endtask

    task automatic send_weight_beat(weight_beat_t beat);
        int waited;
        waited = 0;
        weight_valid_i = 1'b1;
        weight_i = beat;
        while (!weight_ready_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!weight_ready_o) begin
            note_timeout("weight_ready_o never rose");
        end
        @(negedge clk);
        weight_valid_i = 1'b0;
    endtask

    // Rows first_row up to end_row with optional idle gaps of 0 to 3 cycles
    task automatic send_weights(int first_row, int end_row, bit with_gaps);
        int gap;
        for (int row = first_row; row < end_row; row += PAR) begin
            send_weight_beat(build_beat(row));
            if (with_gaps) begin
                gap = int'(random_bits(2));
                repeat (gap) @(negedge clk);
            end
        end
    endtask

    task automatic wait_energy(output energy_t got, output bit seen);
        int waited;
        waited = 0;
        while (!energy_valid_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        seen = energy_valid_o;
        got = energy_o;
        if (!seen) begin
            note_timeout("energy_valid_o never rose after a full frame");
        end
    endtask

    task automatic accept_energy();
        energy_ready_i = 1'b1;
        @(negedge clk);
        energy_ready_i = 1'b0;
    endtask

    // Early ready keeps energy_ready_i high while the frame is still running
    task automatic collect_energy(string what, bit early_ready);
        energy_t got;
        bit      seen;
        energy_ready_i = early_ready;
        wait_energy(got, seen);
        if (seen) begin
            check_energy(got, energy_t'(model_energy()), what);
            check_spins(spin_o, frame_spins, what);
        end
        accept_energy();
    endtask

    task automatic run_frame(string what, bit with_gaps, bit early_ready);
        send_config('0);
        send_spins(frame_spins);
        send_weights(0, NUM, with_gaps);
        collect_energy(what, early_ready);
    endtask

    // No energy before the last weight beat
    task automatic reset_and_idle_check();
        check_flag(energy_valid_o, 1'b0, "energy valid right after reset");
        repeat (10) begin
            @(negedge clk);
            check_flag(energy_valid_o, 1'b0, "energy valid while idle");
        end
        fill_random();
        send_config('0);
        send_spins(frame_spins);
        send_weights(0, NUM - PAR, 1'b0);
        repeat (10) begin
            @(negedge clk);
            check_flag(energy_valid_o, 1'b0, "energy valid before last weight beat");
        end
        send_weights(NUM - PAR, NUM, 1'b0);
        collect_energy("frame finished by its last beat", 1'b0);
    endtask

    task automatic uniform_frames();
        fill_uniform(1'b1, 1, 1, 1);
        run_frame("uniform +1 frame", 1'b0, 1'b0);
        fill_uniform(1'b0, -1, -1, 1);
        run_frame("uniform -1 frame", 1'b0, 1'b0);
        fill_uniform(1'b1, 7, 7, 15);
        run_frame("extreme value frame", 1'b0, 1'b0);
    endtask

    task automatic random_frames();
        for (int n = 0; n < 20; n++) begin
            fill_random();
            if (n == 0) begin
                // Total of -3 must give -1 rather than -2
                fill_uniform(frame_spins[0], 0, 0, 0);
                frame_spins = spin_vec_t'(random_bits(NUM));
                h_vec[0] = frame_spins[0] ? -3 : 3;
                k_vec[0] = 1;
            end
            run_frame($sformatf("random frame %0d", n), 1'b0, 1'b0);
        end
    endtask

    // Held result under a long stall while a config beat offered meanwhile waits in the pipe
    task automatic energy_backpressure();
        energy_t held;
        bit      seen;
        fill_random();
        send_config('0);
        send_spins(frame_spins);
        send_weights(0, NUM, 1'b0);
        wait_energy(held, seen);
        if (!seen) begin
            return;
        end
        check_energy(held, energy_t'(model_energy()), "energy before back-pressure");
        send_config('0);
        repeat (30) begin
            @(negedge clk);
            check_flag(energy_valid_o, 1'b1, "energy valid under back-pressure");
            check_energy(energy_o, held, "energy under back-pressure");
            check_flag(config_ready_o, 1'b0, "config ready under back-pressure");
        end
        accept_energy();
        // Buffered config opens the next frame
        fill_random();
        send_spins(frame_spins);
        send_weights(0, NUM, 1'b0);
        collect_energy("frame after back-pressure", 1'b0);
    endtask

    task automatic weight_stalls();
        for (int n = 0; n < 3; n++) begin
            fill_random();
            run_frame($sformatf("stalled frame %0d", n), 1'b1, 1'b0);
        end
    endtask

    // Large then small totals so that a leftover shows up at once
    task automatic back_to_back_frames();
        fill_uniform(1'b1, 7, 7, 15);
        run_frame("back-to-back extreme frame", 1'b0, 1'b1);
        fill_random();
        run_frame("back-to-back random frame", 1'b0, 1'b1);
        fill_uniform(1'b0, -1, -1, 1);
        run_frame("back-to-back uniform frame", 1'b0, 1'b1);
        fill_random();
        run_frame("back-to-back last frame", 1'b0, 1'b1);
    endtask

    initial begin
        reset_i = 1'b1;
        config_valid_i = 1'b0;
        config_counter_i = '0;
        spin_valid_i = 1'b0;
        spin_i = '0;
        weight_valid_i = 1'b0;
        weight_i = '0;
        energy_ready_i = 1'b0;
        apply_reset();
        reset_and_idle_check();
        uniform_frames();
        random_frames();
        energy_backpressure();
        weight_stalls();
        back_to_back_frames();
        $display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
